//--- Bender.yml
package:
  name: spis

sources:
  - verilog/spis_pkg.sv
  - verilog/spis_fifo.sv
  - verilog/spis_reg.sv
  - verilog/spis_reg_arb.sv
  - verilog/spis_frame.sv
  - verilog/spis_top.sv
  - target: simulation
    files:
      - sim/tb_spis_top.sv

//--- flist.f
verilog/spis_pkg.sv
verilog/spis_fifo.sv
verilog/spis_reg.sv
verilog/spis_reg_arb.sv
verilog/spis_frame.sv
verilog/spis_top.sv
sim/tb_spis_top.sv

//--- sim/tb_spis_top.sv
/* self-checking testbench, spi master model in mode 0 at aclk/8
   a frame is given ten idle cycles after cs_n rises to take effect */
`timescale 1ns/1ps

module tb_spis_top
  import spis_pkg::*;
();

  logic                  aclk;
  logic                  arst_n;
  logic                  sclk;
  logic                  cs_n;
  logic                  mosi;
  logic                  miso;
  logic                  lcl_req;
  logic                  lcl_write;
  logic [REG_ADDR_W-1:0] lcl_addr;
  logic [REG_DATA_W-1:0] lcl_wdata;
  logic                  lcl_gnt;
  logic [REG_DATA_W-1:0] lcl_rdata;
  logic                  wbuf_pop;
  wbuf_entry_t           wbuf_entry;
  logic                  wbuf_empty;
  logic                  rbuf_push;
  rbuf_entry_t           rbuf_data;
  logic                  rbuf_full;
  logic                  cmd_done;
  logic [REG_DATA_W-1:0] status_in;
  logic [REG_DATA_W-1:0] diag0_in;
  logic [REG_DATA_W-1:0] diag1_in;
  logic                  load_diag0;
  logic                  load_diag1;
  logic [REG_DATA_W-1:0] s_cmd;

  int          mism_cnt = 0;
  int          tmo_cnt = 0;
  logic [31:0] rand_state = 32'h5242b1c0;
  logic        spi_done;

  spis_top u_spis_top (.*);

  // 40 ns period
  always #20 aclk = ~aclk;

  ////////////////////
  // arbitration checks
  ////////////////////
  // host grant never without a request
  assert property (@(posedge aclk) disable iff (!arst_n) lcl_gnt |-> lcl_req)
    else begin
      mism_cnt++;
      $display("Mismatch at %0t: lcl_gnt high without lcl_req", $time);
    end

  // a host that lost a tie wins the next cycle
  assert property (@(posedge aclk) disable iff (!arst_n) (lcl_req && !lcl_gnt) |=> lcl_gnt)
    else begin
      mism_cnt++;
      $display("Mismatch at %0t: lcl_gnt did not follow a waiting lcl_req", $time);
    end

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  // n rising edges, then a small drive delay
  task automatic step(input int n);
    repeat (n) @(posedge aclk);
    #1;
  endtask

  task automatic check_val(input logic [47:0] got, input logic [47:0] exp, input string what);
    assert (got === exp)
      else begin
        mism_cnt++;
        $display("Mismatch at %0t: %s, got %0h expected %0h", $time, what, got, exp);
      end
  endtask

  ////////////////////
  // local host driver
  ////////////////////
  // req held until grant, read data taken mid-cycle in the grant cycle
  task automatic bus_access(input logic wr, input logic [15:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    int n;
    n = 0;
    rdata = '0;
    lcl_req = 1'b1;
    lcl_write = wr;
    lcl_addr = addr;
    lcl_wdata = wdata;
    @(negedge aclk);
    while (!lcl_gnt && n < 50) begin
      n++;
      @(negedge aclk);
    end
    if (!lcl_gnt) begin
      tmo_cnt++;
      $display("Timeout at %0t: local access to %h was never granted", $time, addr);
    end else begin
      rdata = lcl_rdata;
    end
    @(posedge aclk);
    #1;
    lcl_req = 1'b0;
    lcl_write = 1'b0;
  endtask

  task automatic host_write(input logic [15:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    bus_access(1'b1, addr, data, unused);
  endtask

  task automatic expect_reg(input logic [15:0] addr, input logic [31:0] exp, input string what);
    logic [31:0] rd;
    bus_access(1'b0, addr, 32'h0, rd);
    check_val(rd, exp, what);
  endtask

  // pops the head of the write buffer after comparing it
  task automatic drain_expect(input logic [47:0] exp, input string what);
    int n;
    n = 0;
    @(negedge aclk);
    while (wbuf_empty && n < 50) begin
      n++;
      @(negedge aclk);
    end
    if (wbuf_empty) begin
      tmo_cnt++;
      $display("Timeout at %0t: write buffer stayed empty", $time);
    end else begin
      check_val(wbuf_entry, exp, what);
    end
    @(posedge aclk);
    #1;
    if (n < 50) begin
      wbuf_pop = 1'b1;
      step(1);
      wbuf_pop = 1'b0;
    end
  endtask

  task automatic push_read_word(input logic [31:0] data);
    check_val(rbuf_full, 1'b0, "read buffer full before push");
    rbuf_data = data;
    rbuf_push = 1'b1;
    step(1);
    rbuf_push = 1'b0;
  endtask

  ////////////////////
  // spi master, mode 0
  ////////////////////
  // mosi set while sclk low, miso sampled as sclk rises
  task automatic spi_frame(input logic [7:0] opc, input logic [15:0] addr,
                           input logic [31:0] data, output logic [31:0] rx);
    logic [55:0] tx;
    int          i;
    tx = {opc, addr, data};
    rx = '0;
    cs_n = 1'b0;
    step(4);
    for (i = 55; i >= 0; i--) begin
      mosi = tx[i];
      // half sclk period at aclk/8
      step(4);
      sclk = 1'b1;
      if (i < 32) begin
        rx = {rx[30:0], miso};
      end
      step(4);
      sclk = 1'b0;
    end
    step(2);
    cs_n = 1'b1;
    mosi = 1'b0;
    // sync, decode and a possibly contended grant
    step(10);
  endtask

  initial begin
    logic [31:0] w;
    logic [31:0] v;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] rx;
    logic [31:0] last_spi;
    logic [31:0] last_lcl;
    logic [15:0] tag;
    logic [47:0] wq[$];
    logic [31:0] rq[$];
    int          k;
    int          n;

    aclk = 1'b0;
    arst_n = 1'b0;
    sclk = 1'b0;
    cs_n = 1'b1;
    mosi = 1'b0;
    lcl_req = 1'b0;
    lcl_write = 1'b0;
    lcl_addr = '0;
    lcl_wdata = '0;
    wbuf_pop = 1'b0;
    rbuf_push = 1'b0;
    rbuf_data = '0;
    cmd_done = 1'b0;
    status_in = '0;
    diag0_in = '0;
    diag1_in = '0;
    load_diag0 = 1'b0;
    load_diag1 = 1'b0;
    spi_done = 1'b0;
    step(4);
    arst_n = 1'b1;
    step(2);

    // reset values
    check_val(miso, 1'b0, "miso after reset");
    check_val(s_cmd, 32'h0, "s_cmd after reset");
    check_val(lcl_gnt, 1'b0, "lcl_gnt after reset");
    expect_reg(ADDR_CMD, 32'h0, "cmd after reset");
    expect_reg(ADDR_STATUS, 32'h0, "status after reset");
    expect_reg(ADDR_DIAG0, 32'h0, "diag0 after reset");
    expect_reg(ADDR_DIAG1, 32'h0, "diag1 after reset");
    expect_reg(ADDR_WBUF_STAT, 32'h0, "wbuf stat after reset");
    expect_reg(ADDR_WBUF_CTRL, 32'h0, "wbuf ctrl after reset");
    expect_reg(ADDR_RBUF_STAT, 32'h0, "rbuf stat after reset");
    expect_reg(ADDR_RBUF_CTRL, 32'h0, "rbuf ctrl after reset");
    for (k = 0; k < 4; k++) begin
      expect_reg(16'h0030 + 16'(4 * k), 32'h0, "reserved word");
    end
    expect_reg(16'h0020, 32'hdeadbeef, "unmapped address");
    expect_reg(16'h0100, 32'hdeadbeef, "unmapped address");

    // spi write to cmd, masked read, cmd_done, spi read
    w = next_rand() | 32'h1;
    spi_frame(OP_REG_WR, ADDR_CMD, w, rx);
    check_val(s_cmd, w, "s_cmd after spi write");
    expect_reg(ADDR_CMD, w & ~32'h00e00000, "cmd read with bits 23:21 cleared");
    cmd_done = 1'b1;
    step(1);
    cmd_done = 1'b0;
    step(1);
    check_val(s_cmd, w & ~32'h1, "s_cmd after cmd_done");
    v = next_rand() & ~32'h1;
    host_write(ADDR_WBUF_CTRL, v);
    spi_frame(OP_REG_RD, ADDR_WBUF_CTRL, 32'h0, rx);
    check_val(rx, v, "spi read of wbuf ctrl");
    host_write(ADDR_WBUF_CTRL, 32'h0);

    // write buffer order, then read buffer order
    for (k = 0; k < 6; k++) begin
      v = next_rand();
      tag = v[15:0];
      w = next_rand();
      wq.push_back({tag, w});
      spi_frame(OP_WBUF_PUSH, tag, w, rx);
    end
    while (wq.size() > 0) begin
      drain_expect(wq.pop_front(), "write buffer entry");
    end
    check_val(wbuf_empty, 1'b1, "write buffer empty after drain");
    for (k = 0; k < 5; k++) begin
      w = next_rand();
      rq.push_back(w);
      push_read_word(w);
    end
    while (rq.size() > 0) begin
      spi_frame(OP_RBUF_POP, 16'h0, 32'h0, rx);
      check_val(rx, rq.pop_front(), "spi pop data");
    end

    ////////////////////
    // overflow, underflow, soft reset
    ////////////////////
    for (k = 0; k < 17; k++) begin
      v = next_rand();
      tag = v[15:0];
      w = next_rand();
      // the seventeenth is dropped
      if (k < 16) begin
        wq.push_back({tag, w});
      end
      spi_frame(OP_WBUF_PUSH, tag, w, rx);
    end
    expect_reg(ADDR_WBUF_STAT, 32'h2, "wbuf overflow flag");
    while (wq.size() > 0) begin
      drain_expect(wq.pop_front(), "write buffer entry after overflow");
    end
    check_val(wbuf_empty, 1'b1, "write buffer empty after sixteen pops");
    spi_frame(OP_RBUF_POP, 16'h0, 32'h0, rx);
    check_val(rx, 32'h0, "spi pop from empty read buffer");
    expect_reg(ADDR_RBUF_STAT, 32'h1, "rbuf underflow flag");

    spi_frame(OP_WBUF_PUSH, 16'h1234, next_rand(), rx);
    check_val(wbuf_empty, 1'b0, "write buffer holds an entry");
    host_write(ADDR_WBUF_CTRL, 32'h1);
    host_write(ADDR_WBUF_CTRL, 32'h0);
    check_val(wbuf_empty, 1'b1, "write buffer empty after soft reset");
    // cleared flags reach the stat word one cycle later
    step(1);
    expect_reg(ADDR_WBUF_STAT, 32'h0, "wbuf flags after soft reset");
    push_read_word(next_rand());
    push_read_word(next_rand());
    host_write(ADDR_RBUF_CTRL, 32'h1);
    host_write(ADDR_RBUF_CTRL, 32'h0);
    step(1);
    expect_reg(ADDR_RBUF_STAT, 32'h0, "rbuf flags after soft reset");
    spi_frame(OP_RBUF_POP, 16'h0, 32'h0, rx);
    check_val(rx, 32'h0, "spi pop after read buffer soft reset");

    // overlapping requesters, distinct addresses
    v = next_rand() & ~32'h1;
    host_write(ADDR_WBUF_CTRL, v);
    last_spi = '0;
    last_lcl = '0;
    fork
      begin
        for (k = 0; k < 3; k++) begin
          w = next_rand();
          spi_frame(OP_REG_WR, ADDR_CMD, w, rx);
          last_spi = w;
          spi_frame(OP_REG_RD, ADDR_WBUF_CTRL, 32'h0, rx);
          check_val(rx, v, "spi read under contention");
        end
        spi_done = 1'b1;
      end
      begin
        n = 0;
        while (!spi_done && n < 4000) begin
          b = next_rand() & ~32'h1;
          host_write(ADDR_RBUF_CTRL, b);
          last_lcl = b;
          // short gap of zero to three cycles
          step(b[3:2]);
          n++;
        end
        if (!spi_done) begin
          tmo_cnt++;
          $display("Timeout at %0t: spi frames still running after host traffic", $time);
        end
      end
    join
    check_val(s_cmd, last_spi, "s_cmd after overlap");
    expect_reg(ADDR_CMD, last_spi & ~32'h00e00000, "cmd after overlap");
    expect_reg(ADDR_RBUF_CTRL, last_lcl, "rbuf ctrl after overlap");

    ////////////////////
    // status and diag
    ////////////////////
    a = next_rand();
    status_in = a;
    step(2);
    b = next_rand();
    status_in = b;
    // read in the same cycle still sees the old word
    expect_reg(ADDR_STATUS, a, "status before update");
    expect_reg(ADDR_STATUS, b, "status one cycle later");
    a = next_rand();
    diag0_in = a;
    diag1_in = ~a;
    step(2);
    expect_reg(ADDR_DIAG0, 32'h0, "diag0 without load");
    expect_reg(ADDR_DIAG1, 32'h0, "diag1 without load");
    load_diag0 = 1'b1;
    step(1);
    load_diag0 = 1'b0;
    diag0_in = next_rand();
    step(2);
    expect_reg(ADDR_DIAG0, a, "diag0 after load");
    expect_reg(ADDR_DIAG1, 32'h0, "diag1 holds");
    load_diag1 = 1'b1;
    step(1);
    load_diag1 = 1'b0;
    diag1_in = next_rand();
    step(2);
    expect_reg(ADDR_DIAG1, ~a, "diag1 after load");
    expect_reg(ADDR_DIAG0, a, "diag0 holds");

    $display("checks done with %0d mismatches and %0d timeouts", mism_cnt, tmo_cnt);
    if (mism_cnt == 0 && tmo_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- verilog/spis_fifo.sv
/* show-ahead fifo, DEPTH must be a power of two
   push while full is dropped, pop while empty does nothing but flag it */
`timescale 1ns/1ps

module spis_fifo #(
  parameter type payload_t = logic [31:0],
  parameter int  DEPTH     = 16
) (
  input  logic     aclk,
  input  logic     arst_n,
  input  logic     soft_reset,
  input  logic     push,
  input  payload_t wr_data,
  input  logic     pop,
  output payload_t rd_data,
  output logic     full,
  output logic     empty,
  output logic     overflow_sticky,
  output logic     underflow_sticky
);

  localparam int PTR_W = $clog2(DEPTH);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             do_push;
  logic             do_pop;

  assign full    = (count == (PTR_W+1)'(DEPTH));
  assign empty   = (count == '0);
  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;

  // head entry always visible
  assign rd_data = mem[rd_ptr];

  always_ff @(posedge aclk) begin
    if (do_push) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  ////////////////////
  // pointers, count and sticky flags
  ////////////////////
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr           <= '0;
      rd_ptr           <= '0;
      count            <= '0;
      overflow_sticky  <= 1'b0;
      underflow_sticky <= 1'b0;
    end else if (soft_reset) begin
      // held level, buffer stays empty
      wr_ptr           <= '0;
      rd_ptr           <= '0;
      count            <= '0;
      overflow_sticky  <= 1'b0;
      underflow_sticky <= 1'b0;
    end else begin
      // pointers wrap on their own width
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
      if (push && full) begin
        overflow_sticky <= 1'b1;
      end
      if (pop && empty) begin
        underflow_sticky <= 1'b1;
      end
    end
  end

endmodule

//--- verilog/spis_frame.sv
/* spi mode 0 slave frame engine, sclk at most aclk/4
   read data must be granted before the first data-phase falling edge
   a frame shorter than 56 bits is dropped */
`timescale 1ns/1ps

module spis_frame
  import spis_pkg::*;
(
  input  logic                  aclk,
  input  logic                  arst_n,
  input  logic                  sclk,
  input  logic                  cs_n,
  input  logic                  mosi,
  output logic                  miso,
  output logic                  reg_req,
  output logic                  reg_write,
  output logic [REG_ADDR_W-1:0] reg_addr,
  output logic [REG_DATA_W-1:0] reg_wdata,
  input  logic                  reg_gnt,
  input  logic [REG_DATA_W-1:0] reg_rdata,
  output logic                  wbuf_push,
  output wbuf_entry_t           wbuf_entry,
  output logic                  rbuf_pop,
  input  rbuf_entry_t           rbuf_entry,
  input  logic                  rbuf_empty
);

  logic [2:0]            sclk_sync;
  logic [2:0]            cs_sync;
  logic [1:0]            mosi_sync;
  logic                  sclk_rise;
  logic                  sclk_fall;
  logic                  cs_s;
  logic                  frame_end;
  logic [CNT_W-1:0]      bit_cnt;
  logic [FRAME_BITS-1:0] in_sr;
  logic                  hdr_evt;
  logic [7:0]            hdr_opc;
  logic [7:0]            opc_q;
  logic                  rd_pend;
  logic                  wr_pend;
  logic                  tx_shift;
  logic [REG_DATA_W-1:0] out_sr;

  ////////////////////
  // pin sync and edges
  ////////////////////
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      sclk_sync <= '0;
      cs_sync   <= '1;
      mosi_sync <= '0;
    end else begin
      sclk_sync <= {sclk_sync[1:0], sclk};
      cs_sync   <= {cs_sync[1:0], cs_n};
      mosi_sync <= {mosi_sync[0], mosi};
    end
  end

  assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
  assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];
  assign cs_s      = cs_sync[1];
  // only a full-length frame counts
  assign frame_end = cs_sync[1] & ~cs_sync[2] & (bit_cnt == CNT_W'(FRAME_BITS));

  // bit counter, held at zero while deselected
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      bit_cnt <= '0;
      hdr_evt <= 1'b0;
    end else begin
      hdr_evt <= sclk_rise & ~cs_s & (bit_cnt == CNT_W'(HDR_BITS - 1));
      if (cs_s) begin
        bit_cnt <= '0;
      end else if (sclk_rise && bit_cnt != CNT_W'(FRAME_BITS)) begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  // msb first, opcode ends up on top
  always_ff @(posedge aclk) begin
    if (!cs_s && sclk_rise && bit_cnt != CNT_W'(FRAME_BITS)) begin
      in_sr <= {in_sr[FRAME_BITS-2:0], mosi_sync[1]};
    end
  end

  // header just completed, opcode sits in bits 23:16
  assign hdr_opc  = in_sr[HDR_BITS-1:HDR_BITS-8];
  assign rbuf_pop = hdr_evt & (hdr_opc == OP_RBUF_POP);

  ////////////////////
  // decode and bus requests
  ////////////////////
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      opc_q     <= '0;
      rd_pend   <= 1'b0;
      wr_pend   <= 1'b0;
      wbuf_push <= 1'b0;
    end else begin
      if (hdr_evt) begin
        opc_q <= hdr_opc;
      end
      // a read dies with its frame
      if (hdr_evt) begin
        rd_pend <= (hdr_opc == OP_REG_RD);
      end else if (reg_gnt || cs_s) begin
        rd_pend <= 1'b0;
      end
      if (frame_end && opc_q == OP_REG_WR) begin
        wr_pend <= 1'b1;
      end else if (reg_gnt) begin
        wr_pend <= 1'b0;
      end
      // one cycle after frame end so reg_wdata is loaded
      wbuf_push <= frame_end & (opc_q == OP_WBUF_PUSH);
    end
  end

  // address from the header, data at frame end
  always_ff @(posedge aclk) begin
    if (hdr_evt) begin
      reg_addr <= in_sr[REG_ADDR_W-1:0];
    end
    if (frame_end) begin
      reg_wdata <= in_sr[REG_DATA_W-1:0];
    end
  end

  assign reg_req         = rd_pend | wr_pend;
  assign reg_write       = wr_pend;
  assign wbuf_entry.tag  = reg_addr;
  assign wbuf_entry.data = reg_wdata;

  ////////////////////
  // miso shifter
  ////////////////////
  assign tx_shift = sclk_fall & (bit_cnt >= CNT_W'(HDR_BITS)) &
                    (bit_cnt < CNT_W'(FRAME_BITS));

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      out_sr <= '0;
      miso   <= 1'b0;
    end else if (cs_s) begin
      out_sr <= '0;
      miso   <= 1'b0;
    end else begin
      // empty pop still pops so the fifo flags underflow
      if (rbuf_pop) begin
        out_sr <= rbuf_empty ? '0 : rbuf_entry.data;
      end else if (rd_pend && reg_gnt) begin
        out_sr <= reg_rdata;
      end else if (tx_shift) begin
        out_sr <= {out_sr[REG_DATA_W-2:0], 1'b0};
      end
      if (tx_shift) begin
        miso <= out_sr[REG_DATA_W-1];
      end
    end
  end

endmodule

//--- verilog/spis_pkg.sv
/* shared constants and buffer payload types for the spi slave block
   frame is fixed at 8-bit opcode, 16-bit address/tag, 32 data bits */
package spis_pkg;

  // register bus
  localparam int REG_ADDR_W = 16;
  localparam int REG_DATA_W = 32;
  localparam int FIFO_DEPTH = 16;

  // frame layout, bits counted from cs_n falling
  localparam int FRAME_BITS = 56;
  localparam int HDR_BITS   = 24;
  localparam int CNT_W      = 6;

  // opcodes
  localparam logic [7:0] OP_REG_WR    = 8'h02;
  localparam logic [7:0] OP_REG_RD    = 8'h03;
  localparam logic [7:0] OP_WBUF_PUSH = 8'h12;
  localparam logic [7:0] OP_RBUF_POP  = 8'h13;

  ////////////////////
  // register map
  ////////////////////
  localparam logic [REG_ADDR_W-1:0] ADDR_CMD        = 16'h0000;
  localparam logic [REG_ADDR_W-1:0] ADDR_STATUS     = 16'h0004;
  localparam logic [REG_ADDR_W-1:0] ADDR_DIAG0      = 16'h0008;
  localparam logic [REG_ADDR_W-1:0] ADDR_DIAG1      = 16'h000c;
  localparam logic [REG_ADDR_W-1:0] ADDR_RSVD_FIRST = 16'h0030;
  localparam logic [REG_ADDR_W-1:0] ADDR_RSVD_LAST  = 16'h003c;
  localparam logic [REG_ADDR_W-1:0] ADDR_WBUF_STAT  = 16'h0040;
  localparam logic [REG_ADDR_W-1:0] ADDR_WBUF_CTRL  = 16'h0044;
  localparam logic [REG_ADDR_W-1:0] ADDR_RBUF_STAT  = 16'h0048;
  localparam logic [REG_ADDR_W-1:0] ADDR_RBUF_CTRL  = 16'h004c;

  localparam logic [REG_DATA_W-1:0] UNMAPPED_DATA = 32'hdeadbeef;

  // write buffer keeps the frame address as a tag
  typedef struct packed {
    logic [REG_ADDR_W-1:0] tag;
    logic [REG_DATA_W-1:0] data;
  } wbuf_entry_t;

  typedef struct packed {
    logic [REG_DATA_W-1:0] data;
  } rbuf_entry_t;

endpackage

//--- verilog/spis_reg.sv
/* control and status registers, read data is combinational
   read data is zero whenever reg_read is low */
`timescale 1ns/1ps

module spis_reg
  import spis_pkg::*;
(
  input  logic                  aclk,
  input  logic                  arst_n,
  input  logic                  reg_write,
  input  logic                  reg_read,
  input  logic [REG_ADDR_W-1:0] reg_addr,
  input  logic [REG_DATA_W-1:0] reg_wdata,
  output logic [REG_DATA_W-1:0] reg_rdata,
  input  logic                  cmd_done,
  input  logic                  load_diag0,
  input  logic                  load_diag1,
  input  logic [REG_DATA_W-1:0] status_in,
  input  logic [REG_DATA_W-1:0] diag0_in,
  input  logic [REG_DATA_W-1:0] diag1_in,
  input  logic                  wbuf_ovf,
  input  logic                  wbuf_unf,
  input  logic                  rbuf_ovf,
  input  logic                  rbuf_unf,
  output logic                  wbuf_soft_reset,
  output logic                  rbuf_soft_reset,
  output logic [REG_DATA_W-1:0] s_cmd
);

  logic [REG_DATA_W-1:0] s_status;
  logic [REG_DATA_W-1:0] s_diag0;
  logic [REG_DATA_W-1:0] s_diag1;
  logic [REG_DATA_W-1:0] wbuf_stat;
  logic [REG_DATA_W-1:0] wbuf_ctrl;
  logic [REG_DATA_W-1:0] rbuf_stat;
  logic [REG_DATA_W-1:0] rbuf_ctrl;
  logic                  rsvd_hit;

  // soft reset levels straight from ctrl bit 0
  assign wbuf_soft_reset = wbuf_ctrl[0];
  assign rbuf_soft_reset = rbuf_ctrl[0];

  ////////////////////
  // register updates
  ////////////////////
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      s_cmd     <= '0;
      s_status  <= '0;
      s_diag0   <= '0;
      s_diag1   <= '0;
      wbuf_stat <= '0;
      wbuf_ctrl <= '0;
      rbuf_stat <= '0;
      rbuf_ctrl <= '0;
    end else begin
      // done beats a same-cycle write, only bit 0 cleared
      if (cmd_done) begin
        s_cmd[0] <= 1'b0;
      end else if (reg_write && reg_addr == ADDR_CMD) begin
        s_cmd <= reg_wdata;
      end
      s_status <= status_in;
      if (load_diag0) begin
        s_diag0 <= diag0_in;
      end
      if (load_diag1) begin
        s_diag1 <= diag1_in;
      end
      // overflow in bit 1, underflow in bit 0
      wbuf_stat <= {30'b0, wbuf_ovf, wbuf_unf};
      rbuf_stat <= {30'b0, rbuf_ovf, rbuf_unf};
      if (reg_write && reg_addr == ADDR_WBUF_CTRL) begin
        wbuf_ctrl <= reg_wdata;
      end
      if (reg_write && reg_addr == ADDR_RBUF_CTRL) begin
        rbuf_ctrl <= reg_wdata;
      end
    end
  end

  // word-aligned hole at 0x30..0x3c
  assign rsvd_hit = (reg_addr >= ADDR_RSVD_FIRST) && (reg_addr <= ADDR_RSVD_LAST) &&
                    (reg_addr[1:0] == 2'b00);

  ////////////////////
  // read mux
  ////////////////////
  always_comb begin
    reg_rdata = '0;
    if (reg_read) begin
      case (reg_addr)
        // bits 23:21 of cmd read back as zero
        ADDR_CMD:       reg_rdata = {s_cmd[31:24], 3'b000, s_cmd[20:0]};
        ADDR_STATUS:    reg_rdata = s_status;
        ADDR_DIAG0:     reg_rdata = s_diag0;
        ADDR_DIAG1:     reg_rdata = s_diag1;
        ADDR_WBUF_STAT: reg_rdata = wbuf_stat;
        ADDR_WBUF_CTRL: reg_rdata = wbuf_ctrl;
        ADDR_RBUF_STAT: reg_rdata = rbuf_stat;
        ADDR_RBUF_CTRL: reg_rdata = rbuf_ctrl;
        default:        reg_rdata = rsvd_hit ? '0 : UNMAPPED_DATA;
      endcase
    end
  end

endmodule

//--- verilog/spis_reg_arb.sv
/* two-way round robin onto the register bus, grant is same-cycle
   requesters hold req, write, addr and wdata until they see gnt */
`timescale 1ns/1ps

module spis_reg_arb
  import spis_pkg::*;
(
  input  logic                  aclk,
  input  logic                  arst_n,
  input  logic                  spi_req,
  input  logic                  spi_write,
  input  logic [REG_ADDR_W-1:0] spi_addr,
  input  logic [REG_DATA_W-1:0] spi_wdata,
  output logic                  spi_gnt,
  input  logic                  lcl_req,
  input  logic                  lcl_write,
  input  logic [REG_ADDR_W-1:0] lcl_addr,
  input  logic [REG_DATA_W-1:0] lcl_wdata,
  output logic                  lcl_gnt,
  output logic                  reg_write,
  output logic                  reg_read,
  output logic [REG_ADDR_W-1:0] reg_addr,
  output logic [REG_DATA_W-1:0] reg_wdata
);

  // set when the host won last, so the frame engine leads after reset
  logic lcl_last;

  // on a tie the one not granted last wins
  assign spi_gnt = spi_req & (~lcl_req | lcl_last);
  assign lcl_gnt = lcl_req & (~spi_req | ~lcl_last);

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      lcl_last <= 1'b1;
    end else if (spi_gnt) begin
      lcl_last <= 1'b0;
    end else if (lcl_gnt) begin
      lcl_last <= 1'b1;
    end
  end

  // bus mux, strobes only in a grant cycle
  assign reg_write = (spi_gnt & spi_write) | (lcl_gnt & lcl_write);
  assign reg_read  = (spi_gnt & ~spi_write) | (lcl_gnt & ~lcl_write);
  assign reg_addr  = lcl_gnt ? lcl_addr : spi_addr;
  assign reg_wdata = lcl_gnt ? lcl_wdata : spi_wdata;

endmodule

//--- verilog/spis_top.sv
/* spi slave register and buffer subsystem, all logic on aclk
   local host and spi frames share the register block round robin */
`timescale 1ns/1ps

module spis_top
  import spis_pkg::*;
(
  input  logic                  aclk,
  input  logic                  arst_n,
  input  logic                  sclk,
  input  logic                  cs_n,
  input  logic                  mosi,
  output logic                  miso,
  input  logic                  lcl_req,
  input  logic                  lcl_write,
  input  logic [REG_ADDR_W-1:0] lcl_addr,
  input  logic [REG_DATA_W-1:0] lcl_wdata,
  output logic                  lcl_gnt,
  output logic [REG_DATA_W-1:0] lcl_rdata,
  input  logic                  wbuf_pop,
  output wbuf_entry_t           wbuf_entry,
  output logic                  wbuf_empty,
  input  logic                  rbuf_push,
  input  rbuf_entry_t           rbuf_data,
  output logic                  rbuf_full,
  input  logic                  cmd_done,
  input  logic [REG_DATA_W-1:0] status_in,
  input  logic [REG_DATA_W-1:0] diag0_in,
  input  logic [REG_DATA_W-1:0] diag1_in,
  input  logic                  load_diag0,
  input  logic                  load_diag1,
  output logic [REG_DATA_W-1:0] s_cmd
);

  // frame engine side of the bus
  logic                  spi_req;
  logic                  spi_write;
  logic [REG_ADDR_W-1:0] spi_addr;
  logic [REG_DATA_W-1:0] spi_wdata;
  logic                  spi_gnt;
  // shared register bus
  logic                  reg_write;
  logic                  reg_read;
  logic [REG_ADDR_W-1:0] reg_addr;
  logic [REG_DATA_W-1:0] reg_wdata;
  logic [REG_DATA_W-1:0] reg_rdata;
  // buffers
  logic                  frm_wbuf_push;
  wbuf_entry_t           frm_wbuf_entry;
  logic                  frm_rbuf_pop;
  rbuf_entry_t           rbuf_head;
  logic                  rbuf_empty;
  logic                  wbuf_ovf;
  logic                  wbuf_unf;
  logic                  rbuf_ovf;
  logic                  rbuf_unf;
  logic                  wbuf_soft_reset;
  logic                  rbuf_soft_reset;

  // host sees the same combinational read data in its grant cycle
  assign lcl_rdata = reg_rdata;

  spis_frame u_frame (
    .aclk       (aclk),
    .arst_n     (arst_n),
    .sclk       (sclk),
    .cs_n       (cs_n),
    .mosi       (mosi),
    .miso       (miso),
    .reg_req    (spi_req),
    .reg_write  (spi_write),
    .reg_addr   (spi_addr),
    .reg_wdata  (spi_wdata),
    .reg_gnt    (spi_gnt),
    .reg_rdata  (reg_rdata),
    .wbuf_push  (frm_wbuf_push),
    .wbuf_entry (frm_wbuf_entry),
    .rbuf_pop   (frm_rbuf_pop),
    .rbuf_entry (rbuf_head),
    .rbuf_empty (rbuf_empty)
  );

  spis_reg_arb u_arb (
    .aclk      (aclk),
    .arst_n    (arst_n),
    .spi_req   (spi_req),
    .spi_write (spi_write),
    .spi_addr  (spi_addr),
    .spi_wdata (spi_wdata),
    .spi_gnt   (spi_gnt),
    .lcl_req   (lcl_req),
    .lcl_write (lcl_write),
    .lcl_addr  (lcl_addr),
    .lcl_wdata (lcl_wdata),
    .lcl_gnt   (lcl_gnt),
    .reg_write (reg_write),
    .reg_read  (reg_read),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata)
  );

  spis_reg u_reg (
    .aclk            (aclk),
    .arst_n          (arst_n),
    .reg_write       (reg_write),
    .reg_read        (reg_read),
    .reg_addr        (reg_addr),
    .reg_wdata       (reg_wdata),
    .reg_rdata       (reg_rdata),
    .cmd_done        (cmd_done),
    .load_diag0      (load_diag0),
    .load_diag1      (load_diag1),
    .status_in       (status_in),
    .diag0_in        (diag0_in),
    .diag1_in        (diag1_in),
    .wbuf_ovf        (wbuf_ovf),
    .wbuf_unf        (wbuf_unf),
    .rbuf_ovf        (rbuf_ovf),
    .rbuf_unf        (rbuf_unf),
    .wbuf_soft_reset (wbuf_soft_reset),
    .rbuf_soft_reset (rbuf_soft_reset),
    .s_cmd           (s_cmd)
  );

  ////////////////////
  // buffers
  ////////////////////
  spis_fifo #(
    .payload_t (wbuf_entry_t),
    .DEPTH     (FIFO_DEPTH)
  ) u_wbuf (
    .aclk             (aclk),
    .arst_n           (arst_n),
    .soft_reset       (wbuf_soft_reset),
    .push             (frm_wbuf_push),
    .wr_data          (frm_wbuf_entry),
    .pop              (wbuf_pop),
    .rd_data          (wbuf_entry),
    .full             (),
    .empty            (wbuf_empty),
    .overflow_sticky  (wbuf_ovf),
    .underflow_sticky (wbuf_unf)
  );

  spis_fifo #(
    .payload_t (rbuf_entry_t),
    .DEPTH     (FIFO_DEPTH)
  ) u_rbuf (
    .aclk             (aclk),
    .arst_n           (arst_n),
    .soft_reset       (rbuf_soft_reset),
    .push             (rbuf_push),
    .wr_data          (rbuf_data),
    .pop              (frm_rbuf_pop),
    .rd_data          (rbuf_head),
    .full             (rbuf_full),
    .empty            (rbuf_empty),
    .overflow_sticky  (rbuf_ovf),
    .underflow_sticky (rbuf_unf)
  );

endmodule
